// File: Bender.yml
package:
  name: tinyrv1_issue

sources:
  - core_cfg_pkg.sv
  - rv_isa_pkg.sv
  - fetch_buffer.sv
  - inst_decoder.sv
  - regfile_scoreboard.sv
  - decode_issue_unit.sv
  - alu_pipe.sv
  - tinyrv1_issue_top.sv
  - target: simulation
    files:
      - tb_tinyrv1_issue.sv

// File: alu_pipe.sv
// ----------------------------------------
// Two-stage ALU pipe with commit port
// Stage one computes, stage two waits for commit and writes back
// ----------------------------------------

`timescale 1ns/1ps

module alu_pipe
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // Issue side
  input  logic                    iss_val,
  output logic                    iss_rdy,
  input  rv_uop                   iss_uop,
  input  logic [addr_bits-1:0]    iss_pc,
  input  logic [data_bits-1:0]    iss_op1,
  input  logic [data_bits-1:0]    iss_op2,
  input  logic [reg_idx_bits-1:0] iss_waddr,
  input  logic                    iss_wen,

  // Commit port
  output logic                    commit_val,
  output logic [addr_bits-1:0]    commit_pc,
  output logic [reg_idx_bits-1:0] commit_waddr,
  output logic                    commit_wen,
  output logic [data_bits-1:0]    commit_data,
  input  logic                    commit_rdy,

  // Writeback into the register file
  output logic                    wb_en,
  output logic [reg_idx_bits-1:0] wb_addr,
  output logic [data_bits-1:0]    wb_data
);

  // Valid per stage, index 0 is the compute stage
  logic [alu_stages-1:0] stage_val;

  // Stage one payload
  rv_uop                   s1_uop;
  logic [addr_bits-1:0]    s1_pc;
  logic [data_bits-1:0]    s1_op1;
  logic [data_bits-1:0]    s1_op2;
  logic [reg_idx_bits-1:0] s1_waddr;
  logic                    s1_wen;
  logic [data_bits-1:0]    s1_result;

  logic iss_xfer;
  logic commit_xfer;
  logic s2_free;
  logic s1_adv;

  // ----------------------------------------
  // Flow control
  // ----------------------------------------

  assign commit_xfer = commit_val && commit_rdy;
  assign s2_free     = !stage_val[1] || commit_xfer;
  assign s1_adv      = stage_val[0] && s2_free;
  assign iss_rdy     = !stage_val[0] || s2_free;
  assign iss_xfer    = iss_val && iss_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_val <= '0;
    end else begin
      if (iss_xfer) begin
        stage_val[0] <= 1'b1;
      end else if (s1_adv) begin
        stage_val[0] <= 1'b0;
      end
      if (s1_adv) begin
        stage_val[1] <= 1'b1;
      end else if (commit_xfer) begin
        stage_val[1] <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Stage one, operand capture and compute
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (iss_xfer) begin
      s1_uop   <= iss_uop;
      s1_pc    <= iss_pc;
      s1_op1   <= iss_op1;
      s1_op2   <= iss_op2;
      s1_waddr <= iss_waddr;
      s1_wen   <= iss_wen;
    end
  end

  always_comb begin
    case (s1_uop)
      uop_add,
      uop_addi: s1_result = s1_op1 + s1_op2;
      // Low word of the product
      uop_mul:  s1_result = s1_op1 * s1_op2;
      default:  s1_result = '0;
    endcase
  end

  // ----------------------------------------
  // Stage two, commit
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (s1_adv) begin
      commit_pc    <= s1_pc;
      commit_waddr <= s1_waddr;
      commit_wen   <= s1_wen;
      commit_data  <= s1_result;
    end
  end

  assign commit_val = stage_val[1];

  // Register write only on an accepted commit
  assign wb_en   = commit_xfer && commit_wen;
  assign wb_addr = commit_waddr;
  assign wb_data = commit_data;

endmodule

// File: core_cfg_pkg.sv
// ----------------------------------------
// Core sizing for the decode and issue stage
// Widths, register count and execute depth
// ----------------------------------------

package core_cfg_pkg;

  // Registers, operands and results
  localparam int data_bits    = 32;
  // Program counter
  localparam int addr_bits    = 32;
  // Instruction word
  localparam int inst_bits    = 32;
  // Architectural register file
  localparam int reg_idx_bits = 5;
  localparam int num_regs     = 32;
  // Stages in the ALU pipe
  localparam int alu_stages   = 2;

endpackage

// File: decode_issue_unit.sv
// ----------------------------------------
// Decode and issue for the TinyRV1 core
// Reads operands, stalls on pending sources, issues to the ALU pipe
// ----------------------------------------

`timescale 1ns/1ps

module decode_issue_unit
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // From the fetch buffer
  input  logic                    buf_val,
  input  logic [inst_bits-1:0]    buf_inst,
  input  logic [addr_bits-1:0]    buf_pc,
  output logic                    buf_take,

  // Issue to the ALU pipe
  output logic                    iss_val,
  input  logic                    iss_rdy,
  output rv_uop                   iss_uop,
  output logic [addr_bits-1:0]    iss_pc,
  output logic [data_bits-1:0]    iss_op1,
  output logic [data_bits-1:0]    iss_op2,
  output logic [reg_idx_bits-1:0] iss_waddr,
  output logic                    iss_wen,

  // Writeback from commit
  input  logic                    wb_en,
  input  logic [reg_idx_bits-1:0] wb_addr,
  input  logic [data_bits-1:0]    wb_data
);

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  logic [reg_idx_bits-1:0] dec_raddr0;
  logic [reg_idx_bits-1:0] dec_raddr1;
  logic                    dec_op2_sel;
  logic [data_bits-1:0]    dec_imm;

  inst_decoder decoder_i (
    .inst    (buf_inst),
    .uop     (iss_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (iss_waddr),
    .wen     (iss_wen),
    .op2_sel (dec_op2_sel),
    .imm     (dec_imm)
  );

  // ----------------------------------------
  // Operands and scoreboard
  // ----------------------------------------

  logic [data_bits-1:0] rdata0;
  logic [data_bits-1:0] rdata1;
  logic                 pend0;
  logic                 pend1;

  regfile_scoreboard regfile_i (
    .clk           (clk),
    .rst           (rst),
    .raddr0        (dec_raddr0),
    .raddr1        (dec_raddr1),
    .rdata0        (rdata0),
    .rdata1        (rdata1),
    .wen           (wb_en),
    .waddr         (wb_addr),
    .wdata         (wb_data),
    .set_pend_en   (buf_take && iss_wen),
    .set_pend_addr (iss_waddr),
    .pend0         (pend0),
    .pend1         (pend1)
  );

  // Unused sources read x0, so only real sources can stall
  assign iss_val  = buf_val && !pend0 && !pend1;
  assign buf_take = iss_val && iss_rdy;

  assign iss_pc  = buf_pc;
  assign iss_op1 = rdata0;
  // Immediate replaces rs2 for addi
  assign iss_op2 = dec_op2_sel ? dec_imm : rdata1;

endmodule

// File: fetch_buffer.sv
// ----------------------------------------
// One-entry instruction buffer on the fetch side
// Accepts inst/pc on val/rdy and holds them for decode
// ----------------------------------------

`timescale 1ns/1ps

module fetch_buffer
  import core_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,

  // Fetch port
  input  logic                 fetch_val,
  input  logic [inst_bits-1:0] fetch_inst,
  input  logic [addr_bits-1:0] fetch_pc,
  output logic                 fetch_rdy,

  // Towards decode
  output logic                 buf_val,
  output logic [inst_bits-1:0] buf_inst,
  output logic [addr_bits-1:0] buf_pc,
  input  logic                 buf_take
);

  logic fetch_xfer;

  // Room when empty, or when the current entry issues this cycle
  assign fetch_rdy  = !buf_val || buf_take;
  assign fetch_xfer = fetch_val && fetch_rdy;

  // Valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      buf_val <= 1'b0;
    end else if (fetch_xfer) begin
      buf_val <= 1'b1;
    end else if (buf_take) begin
      buf_val <= 1'b0;
    end
  end

  // Payload, only meaningful while buf_val is high
  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      buf_inst <= fetch_inst;
      buf_pc   <= fetch_pc;
    end
  end

endmodule

// File: files.f
core_cfg_pkg.sv
rv_isa_pkg.sv
fetch_buffer.sv
inst_decoder.sv
regfile_scoreboard.sv
decode_issue_unit.sv
alu_pipe.sv
tinyrv1_issue_top.sv
tb_tinyrv1_issue.sv

// File: inst_decoder.sv
// ----------------------------------------
// TinyRV1 instruction decoder
// Purely combinational, maps an instruction word to a micro-op
// ----------------------------------------

`timescale 1ns/1ps

module inst_decoder
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic [inst_bits-1:0]    inst,
  output rv_uop                   uop,
  output logic [reg_idx_bits-1:0] raddr0,
  output logic [reg_idx_bits-1:0] raddr1,
  output logic [reg_idx_bits-1:0] waddr,
  output logic                    wen,
  output logic                    op2_sel,
  output logic [data_bits-1:0]    imm
);

  // ----------------------------------------
  // Instruction fields
  // ----------------------------------------

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [reg_idx_bits-1:0] rd;
  logic [reg_idx_bits-1:0] rs1;
  logic [reg_idx_bits-1:0] rs2;
  rv_imm_type              imm_sel;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // ----------------------------------------
  // Opcode match
  // ----------------------------------------

  always_comb begin
    // Unsupported encodings fall through as a no-op
    // Reading x0 keeps them clear of the scoreboard
    uop     = uop_nop;
    raddr0  = '0;
    raddr1  = '0;
    waddr   = '0;
    wen     = 1'b0;
    imm_sel = imm_none;

    if (opcode == op_reg && funct3 == funct3_add && funct7 == funct7_add) begin
      uop    = uop_add;
      raddr0 = rs1;
      raddr1 = rs2;
      waddr  = rd;
      wen    = (rd != '0);
    end else if (opcode == op_reg && funct3 == funct3_mul && funct7 == funct7_mul) begin
      uop    = uop_mul;
      raddr0 = rs1;
      raddr1 = rs2;
      waddr  = rd;
      wen    = (rd != '0);
    end else if (opcode == op_imm && funct3 == funct3_addi) begin
      // Second source unused, op2 comes from the immediate
      uop     = uop_addi;
      raddr0  = rs1;
      waddr   = rd;
      wen     = (rd != '0);
      imm_sel = imm_i;
    end
  end

  // ----------------------------------------
  // Immediate
  // ----------------------------------------

  // I-type, sign-extended from bit 31
  assign imm = (imm_sel == imm_i) ?
               {{(data_bits-12){inst[inst_bits-1]}}, inst[31:20]} : '0;

  assign op2_sel = (imm_sel == imm_i);

endmodule

// File: issue_cases.txt
// inst pc waddr wen data, all hex, one instruction per line in program order
// waddr/wen/data give the commit expected for that instruction
00500093 00000000 01 1 00000005
00700113 00000004 02 1 00000007
002081b3 00000008 03 1 0000000c
02218233 0000000c 04 1 00000054
f9c20293 00000010 05 1 fffffff0
02528333 00000014 06 1 00000100
7ff00393 00000018 07 1 000007ff
02738433 0000001c 08 1 003ff001
028404b3 00000020 09 1 017fe001
00908013 00000024 00 0 00000000
00100533 00000028 0a 1 00000005
0000a583 0000002c 00 0 00000000
000000ef 00000030 00 0 00000000
00008633 00000034 0c 1 00000005
001080b3 00000038 01 1 0000000a
001080b3 0000003c 01 1 00000014
001080b3 00000040 01 1 00000028
025086b3 00000044 0d 1 fffffd80
28068713 00000048 0e 1 00000000
00209463 0000004c 00 0 00000000
fff70793 00000050 0f 1 ffffffff
02f78833 00000054 10 1 00000001
009808b3 00000058 11 1 017fe002

// File: regfile_scoreboard.sv
// ----------------------------------------
// Register file with pending-write tracking
// Two write-through read ports, one write port, x0 tied to zero
// ----------------------------------------

`timescale 1ns/1ps

module regfile_scoreboard
  import core_cfg_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // Read ports
  input  logic [reg_idx_bits-1:0] raddr0,
  input  logic [reg_idx_bits-1:0] raddr1,
  output logic [data_bits-1:0]    rdata0,
  output logic [data_bits-1:0]    rdata1,

  // Writeback, also releases the pending mark
  input  logic                    wen,
  input  logic [reg_idx_bits-1:0] waddr,
  input  logic [data_bits-1:0]    wdata,

  // Issue marks the destination pending
  input  logic                    set_pend_en,
  input  logic [reg_idx_bits-1:0] set_pend_addr,
  output logic                    pend0,
  output logic                    pend1
);

  logic [data_bits-1:0] regs [num_regs];

  // Writes in flight per register
  // Two slots since the ALU pipe holds at most two items
  logic [1:0] pend_cnt [num_regs];
  logic [num_regs-1:0] pend;

  // Data array, x0 is never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Pending counts, set and clear on one register cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        pend_cnt[i] <= 2'd0;
      end
    end else begin
      for (int i = 1; i < num_regs; i++) begin
        pend_cnt[i] <= pend_cnt[i]
                       + 2'((set_pend_en && set_pend_addr == reg_idx_bits'(i)))
                       - 2'((wen && waddr == reg_idx_bits'(i)));
      end
    end
  end

  // Pending after this cycle's writeback is taken off
  always_comb begin
    for (int i = 0; i < num_regs; i++) begin
      pend[i] = (pend_cnt[i] > 2'd1) ||
                (pend_cnt[i] == 2'd1 && !(wen && waddr == reg_idx_bits'(i)));
    end
  end

  assign pend0 = pend[raddr0];
  assign pend1 = pend[raddr1];

  // Write-through reads
  assign rdata0 = (raddr0 == '0)                 ? '0    :
                  (wen && waddr == raddr0)       ? wdata : regs[raddr0];
  assign rdata1 = (raddr1 == '0)                 ? '0    :
                  (wen && waddr == raddr1)       ? wdata : regs[raddr1];

endmodule

// File: rv_isa_pkg.sv
// ----------------------------------------
// TinyRV1 encodings and decoded micro-ops
// Shared by the decoder, the issue unit and the ALU pipe
// ----------------------------------------

package rv_isa_pkg;

  // ----------------------------------------
  // Major opcodes
  // ----------------------------------------

  // Register-register ALU ops (add, mul)
  localparam logic [6:0] op_reg = 7'b0110011;
  // Register-immediate ALU ops (addi)
  localparam logic [6:0] op_imm = 7'b0010011;

  // ----------------------------------------
  // Function fields
  // ----------------------------------------

  localparam logic [2:0] funct3_add  = 3'b000;
  localparam logic [2:0] funct3_addi = 3'b000;
  localparam logic [2:0] funct3_mul  = 3'b000;

  localparam logic [6:0] funct7_add = 7'b0000000;
  // M-extension marker, mul shares funct3 with add
  localparam logic [6:0] funct7_mul = 7'b0000001;

  // ----------------------------------------
  // Decoded forms
  // ----------------------------------------

  // Micro-op sent down the execute pipe
  // uop_nop covers every unsupported encoding
  typedef enum logic [1:0] {
    uop_add  = 2'd0,
    uop_addi = 2'd1,
    uop_mul  = 2'd2,
    uop_nop  = 2'd3
  } rv_uop;

  // Immediate format picked by the decoder
  typedef enum logic {
    imm_i    = 1'b0,
    imm_none = 1'b1
  } rv_imm_type;

endpackage

// File: tb_tinyrv1_issue.sv
// ----------------------------------------
// Self-checking testbench for the TinyRV1 decode and issue stage
// Feeds instructions from issue_cases.txt, checks every commit in order
// ----------------------------------------

`timescale 1ns/1ps

module tb_tinyrv1_issue;

  localparam int max_wait = 200;

  logic        clk;
  logic        rst;
  logic        fetch_val;
  logic [31:0] fetch_inst;
  logic [31:0] fetch_pc;
  logic        fetch_rdy;
  logic        commit_val;
  logic [31:0] commit_pc;
  logic [4:0]  commit_waddr;
  logic        commit_wen;
  logic [31:0] commit_data;
  logic        commit_rdy;

  // Expected program with one entry per cases line
  logic [31:0] case_inst  [$];
  logic [31:0] case_pc    [$];
  logic [31:0] case_waddr [$];
  logic [31:0] case_wen   [$];
  logic [31:0] case_data  [$];

  int num_cases;
  int commit_count;
  bit all_done;

  tinyrv1_issue_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_val    (fetch_val),
    .fetch_inst   (fetch_inst),
    .fetch_pc     (fetch_pc),
    .fetch_rdy    (fetch_rdy),
    .commit_val   (commit_val),
    .commit_pc    (commit_pc),
    .commit_waddr (commit_waddr),
    .commit_wen   (commit_wen),
    .commit_data  (commit_data),
    .commit_rdy   (commit_rdy)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // Reporting
  // ----------------------------------------

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("FAIL time=%0t %s actual=%h expected=%h",
                                $time, name, actual, expected));
    end
  endtask

  // ----------------------------------------
  // Case file
  // ----------------------------------------

  task automatic load_cases();
    int fd;
    int got;
    int n;
    bit is_comment;
    string line;
    logic [31:0] f_inst, f_pc, f_waddr, f_wen, f_data;
    fd = $fopen("issue_cases.txt", "r");
    if (fd == 0) begin
      stop_with_error("Could not open issue_cases.txt for reading");
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      is_comment = (line.len() < 2) ? 1'b1 : (line.substr(0, 1) == "//");
      if (got != 0 && !is_comment) begin
        n = $sscanf(line, "%h %h %h %h %h", f_inst, f_pc, f_waddr, f_wen, f_data);
        // Blank or short lines are skipped
        if (n == 5) begin
          case_inst.push_back(f_inst);
          case_pc.push_back(f_pc);
          case_waddr.push_back(f_waddr);
          case_wen.push_back(f_wen);
          case_data.push_back(f_data);
        end
      end
    end
    $fclose(fd);
    num_cases = case_inst.size();
  endtask

  // ----------------------------------------
  // Fetch side
  // ----------------------------------------

  // Called 2 ns after a rising edge and returns 2 ns after the transfer edge
  task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
    int waited;
    waited = 0;
    fetch_val  = 1'b1;
    fetch_inst = inst;
    fetch_pc   = pc;
    @(negedge clk);
    while (!fetch_rdy) begin
      waited++;
      if (waited > max_wait) begin
        stop_with_error("Timeout: fetch_rdy stayed low for 200 cycles");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    fetch_val = 1'b0;
  endtask

  task automatic drive_fetch();
    int gap;
    for (int i = 0; i < num_cases; i++) begin
      // Occasional idle cycles between instructions
      gap = (($urandom % 3) == 0) ? int'($urandom % 3) + 1 : 0;
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      send_inst(case_inst[i], case_pc[i]);
    end
  endtask

  // ----------------------------------------
  // Commit side
  // ----------------------------------------

  // Ready low about 30% of the cycles
  task automatic drive_commit_rdy();
    int cycles;
    cycles = 0;
    while (!all_done && cycles < max_wait * 100) begin
      @(posedge clk);
      #2;
      commit_rdy = (($urandom % 100) >= 30);
      cycles++;
    end
    if (!all_done) begin
      stop_with_error("Timeout: commits did not finish within the cycle limit");
    end
  endtask

  // Sampled at the falling edge, where outputs and ready are settled
  task automatic watch_commits();
    int idle;
    while (commit_count < num_cases) begin
      idle = 0;
      @(negedge clk);
      while (!(commit_val && commit_rdy)) begin
        idle++;
        if (idle > max_wait) begin
          stop_with_error($sformatf("Timeout: no commit for 200 cycles, %0d of %0d done",
                                    commit_count, num_cases));
        end
        @(negedge clk);
      end
      check_value("commit_pc", commit_pc, case_pc[commit_count]);
      check_value("commit_waddr", 32'(commit_waddr), case_waddr[commit_count]);
      check_value("commit_wen", 32'(commit_wen), case_wen[commit_count]);
      // Result only matters when a register is written
      if (case_wen[commit_count] != 0) begin
        check_value("commit_data", commit_data, case_data[commit_count]);
      end
      commit_count++;
    end
    all_done = 1'b1;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    rst          = 1'b1;
    fetch_val    = 1'b0;
    fetch_inst   = '0;
    fetch_pc     = '0;
    commit_rdy   = 1'b0;
    commit_count = 0;
    all_done     = 1'b0;
    void'($urandom(21143));

    load_cases();
    if (num_cases == 0) begin
      stop_with_error("No cases found in issue_cases.txt");
    end

    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    // Idle after reset leaves commit empty and fetch open
    repeat (4) begin
      @(negedge clk);
      check_value("commit_val", 32'(commit_val), 32'd0);
      check_value("fetch_rdy", 32'(fetch_rdy), 32'd1);
    end
    @(posedge clk);
    #2;

    fork
      drive_fetch();
      drive_commit_rdy();
      watch_commits();
    join

    // No extra commits once the program has drained
    commit_rdy = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_value("commit_val", 32'(commit_val), 32'd0);
      check_value("fetch_rdy", 32'(fetch_rdy), 32'd1);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: tinyrv1_issue_top.sv
// ----------------------------------------
// Top level of the TinyRV1 decode and issue stage
// Fetch port in, commit port out
// ----------------------------------------

`timescale 1ns/1ps

module tinyrv1_issue_top
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // Fetch port
  input  logic                    fetch_val,
  input  logic [inst_bits-1:0]    fetch_inst,
  input  logic [addr_bits-1:0]    fetch_pc,
  output logic                    fetch_rdy,

  // Commit port
  output logic                    commit_val,
  output logic [addr_bits-1:0]    commit_pc,
  output logic [reg_idx_bits-1:0] commit_waddr,
  output logic                    commit_wen,
  output logic [data_bits-1:0]    commit_data,
  input  logic                    commit_rdy
);

  // Buffer to decode
  logic                    buf_val;
  logic [inst_bits-1:0]    buf_inst;
  logic [addr_bits-1:0]    buf_pc;
  logic                    buf_take;

  // Issue link
  logic                    iss_val;
  logic                    iss_rdy;
  rv_uop                   iss_uop;
  logic [addr_bits-1:0]    iss_pc;
  logic [data_bits-1:0]    iss_op1;
  logic [data_bits-1:0]    iss_op2;
  logic [reg_idx_bits-1:0] iss_waddr;
  logic                    iss_wen;

  // Writeback link
  logic                    wb_en;
  logic [reg_idx_bits-1:0] wb_addr;
  logic [data_bits-1:0]    wb_data;

  fetch_buffer fetch_buffer_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_val  (fetch_val),
    .fetch_inst (fetch_inst),
    .fetch_pc   (fetch_pc),
    .fetch_rdy  (fetch_rdy),
    .buf_val    (buf_val),
    .buf_inst   (buf_inst),
    .buf_pc     (buf_pc),
    .buf_take   (buf_take)
  );

  decode_issue_unit decode_issue_i (
    .clk       (clk),
    .rst       (rst),
    .buf_val   (buf_val),
    .buf_inst  (buf_inst),
    .buf_pc    (buf_pc),
    .buf_take  (buf_take),
    .iss_val   (iss_val),
    .iss_rdy   (iss_rdy),
    .iss_uop   (iss_uop),
    .iss_pc    (iss_pc),
    .iss_op1   (iss_op1),
    .iss_op2   (iss_op2),
    .iss_waddr (iss_waddr),
    .iss_wen   (iss_wen),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  alu_pipe alu_pipe_i (
    .clk          (clk),
    .rst          (rst),
    .iss_val      (iss_val),
    .iss_rdy      (iss_rdy),
    .iss_uop      (iss_uop),
    .iss_pc       (iss_pc),
    .iss_op1      (iss_op1),
    .iss_op2      (iss_op2),
    .iss_waddr    (iss_waddr),
    .iss_wen      (iss_wen),
    .commit_val   (commit_val),
    .commit_pc    (commit_pc),
    .commit_waddr (commit_waddr),
    .commit_wen   (commit_wen),
    .commit_data  (commit_data),
    .commit_rdy   (commit_rdy),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

endmodule
